// File: list.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_exec_pkg.sv
hw/instruction_decoder.sv
hw/immediate_generator.sv
hw/register_file.sv
hw/arithmetic_logic_unit.sv
hw/execute_control.sv
hw/execute_top.sv
sim/execute_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = execute_tb
FILE_LIST = list.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +incdir+%,$(shell cat $(FILE_LIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/execute_tb.sv
////////////////////
// Self-checking testbench for execute_top, needs a simulator with timing support
// Model holds architectural registers, so DUT forwarding must hide the late writeback
////////////////////
`include "rv_exec_defs.svh"

module execute_tb;
    import rv_exec_pkg::*;

    localparam logic [6:0] OPCODE_IMM   = 7'b0010011;
    localparam logic [6:0] OPCODE_REG   = 7'b0110011;
    localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;   // Not handled by the slice

    logic      clk;
    logic      reset;
    logic      req;
    exec_req_t req_data;
    logic      ack;
    exec_rsp_t rsp;

    logic [31:0] model_regs [`RV_REG_COUNT];   // Architectural view, no lag
    int          cycle_count = 0;
    int          issued_count = 0;

    execute_top i_execute_top (
        .clk(clk), .reset(reset), .req(req), .req_data(req_data), .ack(ack), .rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // Period 20
    end

    // Run limit scales with the instructions issued so far
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > 20 * issued_count + 100) begin
            stop_with_failure($sformatf("Timeout: no handshake progress after %0d cycles",
                                        cycle_count));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic compare_value(input string name, input logic [37:0] expected,
                                 input logic [37:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("** Error %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;   // Drive and sample away from the edge
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm12, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm20, input logic [4:0] rd);
        return {imm20, rd, OPCODE_AUIPC};
    endfunction

    function automatic logic [4:0] random_reg();
        return 5'($urandom_range(0, 7));   // Small window, many dependencies
    endfunction

    // RV32I integer operation by funct3, alt picks SUB or SRA
    function automatic logic [31:0] rv_operation(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];   // Sign fill
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] model_execute(input logic [31:0] pc,
                                                  input logic [31:0] instr,
                                                  output logic illegal);
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm_i;
        logic [31:0] result;
        logic [6:0]  f7;
        logic [2:0]  f3;
        rs1_val = model_regs[instr[19:15]];
        rs2_val = model_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        f7      = instr[31:25];
        f3      = instr[14:12];
        illegal = 1'b0;
        result  = '0;
        case (instr[6:0])
            OPCODE_IMM: begin   // funct7 only checked for shifts
                if (f3 == 3'd1) begin
                    illegal = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    illegal = (f7 != 7'h00) && (f7 != 7'h20);
                end
                result = rv_operation(f3, (f3 == 3'd5) && (f7 == 7'h20), rs1_val, imm_i);
            end
            OPCODE_REG: begin   // 0100000 only for SUB and SRA
                illegal = (f7 != 7'h00) && !((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
                result  = rv_operation(f3, f7 == 7'h20, rs1_val, rs2_val);
            end
            OPCODE_AUIPC: result = pc + {instr[31:12], 12'b0};
            default: illegal = 1'b1;
        endcase
        return result;
    endfunction

    // One full four-phase transaction with timing and response checks
    task automatic issue_instruction(input string name, input logic [31:0] pc,
                                     input logic [31:0] instr);
        logic [31:0] expected;
        logic        exp_illegal;
        exec_rsp_t   held_rsp;
        int          wait_cycles;
        int          hold_cycles;
        expected       = model_execute(pc, instr, exp_illegal);
        issued_count   = issued_count + 1;
        req_data.pc    = pc;
        req_data.instr = instr;
        req            = 1'b1;
        step_cycle();                 // Edge that samples req high
        wait_cycles = 0;
        while (!ack) begin
            step_cycle();
            wait_cycles++;
        end
        compare_value({name, " ack rise delay"}, 38'd2, 38'(wait_cycles));
        compare_value({name, " illegal"}, 38'(exp_illegal), 38'(rsp.illegal));
        compare_value({name, " rd"}, 38'(instr[11:7]), 38'(rsp.rd));
        if (!exp_illegal) begin
            compare_value({name, " result"}, 38'(expected), 38'(rsp.result));
            if (instr[11:7] != 5'd0) begin
                model_regs[instr[11:7]] = expected;
            end
        end
        held_rsp    = rsp;
        hold_cycles = $urandom_range(0, 3);   // Back-pressure
        repeat (hold_cycles) begin
            step_cycle();
            compare_value({name, " ack held"}, 38'd1, 38'(ack));
            compare_value({name, " rsp held"}, held_rsp, rsp);
        end
        req = 1'b0;
        step_cycle();                 // Edge that samples req low
        wait_cycles = 0;
        while (ack) begin
            step_cycle();
            wait_cycles++;
        end
        compare_value({name, " ack fall delay"}, 38'd1, 38'(wait_cycles));
    endtask

    // Every OP-IMM funct3 and every legal OP funct pair, odd rounds take SUB/SRA/SRAI
    task automatic run_random_round(input int round);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [6:0]  f7;
        alt = 1'(round);
        for (int k = 0; k < 8; k++) begin
            f3    = 3'(k);
            imm12 = 12'($urandom);
            if (f3 == 3'd1) begin
                imm12[11:5] = 7'h00;
            end else if (f3 == 3'd5) begin
                imm12[11:5] = alt ? 7'h20 : 7'h00;
            end
            f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            issue_instruction($sformatf("random %0d op-imm f3=%0d", round, k), $urandom,
                              i_type(imm12, random_reg(), f3, random_reg(), OPCODE_IMM));
            issue_instruction($sformatf("random %0d op f3=%0d", round, k), $urandom,
                              r_type(f7, random_reg(), random_reg(), f3, random_reg()));
        end
        issue_instruction($sformatf("random %0d auipc", round), $urandom,
                          u_type(20'($urandom), random_reg()));
    endtask

    initial begin
        void'($urandom(32'h3ff3_e8cd));
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        compare_value("ack after reset", 38'd0, 38'(ack));

        for (int r = 1; r < 8; r++) begin   // Full-width seeds for x1..x7
            issue_instruction($sformatf("load x%0d", r), $urandom,
                              u_type(20'($urandom), 5'(r)));
        end

        // Forwarding, including both operands from the producer
        issue_instruction("fwd producer", 32'h0, i_type(12'h7ff, 5'd0, 3'd0, 5'd9, OPCODE_IMM));
        issue_instruction("fwd same reg", 32'h0, r_type(7'h00, 5'd9, 5'd9, 3'd0, 5'd10));
        issue_instruction("fwd chain", 32'h0, r_type(7'h20, 5'd10, 5'd9, 3'd0, 5'd11));
        issue_instruction("fwd sra", 32'h0, r_type(7'h20, 5'd9, 5'd11, 3'd5, 5'd11));

        // x0 ignores writes
        issue_instruction("x0 write", 32'h0, i_type(12'h123, 5'd9, 3'd0, 5'd0, OPCODE_IMM));
        issue_instruction("x0 read", 32'h0, r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd12));

        issue_instruction("auipc", 32'h8000_1234, u_type(20'hfffff, 5'd13));

        // Illegal encodings aimed at x9, each followed by a read of x9
        issue_instruction("illegal mul", 32'h0, r_type(7'h01, 5'd9, 5'd9, 3'd0, 5'd9));
        issue_instruction("after mul", 32'h0, i_type(12'h000, 5'd9, 3'd0, 5'd14, OPCODE_IMM));
        issue_instruction("illegal slli", 32'h0, i_type(12'h41f, 5'd9, 3'd1, 5'd9, OPCODE_IMM));
        issue_instruction("after slli", 32'h0, r_type(7'h00, 5'd9, 5'd0, 3'd0, 5'd14));
        issue_instruction("illegal load", 32'h0, i_type(12'h010, 5'd0, 3'd2, 5'd9, OPCODE_LOAD));
        issue_instruction("after load", 32'h0, r_type(7'h00, 5'd0, 5'd9, 3'd6, 5'd15));

        for (int round = 0; round < 8; round++) begin
            run_random_round(round);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: hw/execute_top.sv
////////////////////
// RV32I integer execute slice behind a four-phase req/ack port
// One instruction in flight, writeback lags by one instruction
////////////////////
`include "rv_exec_defs.svh"

module execute_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  rv_exec_pkg::exec_req_t req_data,
    output logic                   ack,
    output rv_exec_pkg::exec_rsp_t rsp
);
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    logic [31:0]              instr;
    logic [`RV_XLEN-1:0]      pc;
    decoded_t                 dec;
    logic [`RV_XLEN-1:0]      imm;
    logic [`RV_REG_IDX_W-1:0] rs1_idx, rs2_idx;
    logic [`RV_XLEN-1:0]      rs1_data, rs2_data;
    op1_sel_e                 op1_sel;
    op2_sel_e                 op2_sel;
    alu_op_e                  alu_op;
    logic [`RV_XLEN-1:0]      fwd_data;
    logic [`RV_XLEN-1:0]      alu_result;
    logic                     wr_en;
    logic [`RV_REG_IDX_W-1:0] wr_idx;
    logic [`RV_XLEN-1:0]      wr_data;

    instruction_decoder i_instruction_decoder (.instr(instr), .dec(dec));

    immediate_generator i_immediate_generator (.instr(instr), .imm(imm));

    register_file i_register_file (
        .clk(clk), .reset(reset),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    execute_control i_execute_control (
        .clk(clk), .reset(reset),
        .req(req), .req_data(req_data), .ack(ack), .rsp(rsp),
        .instr(instr), .pc(pc), .dec(dec), .imm(imm),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .alu_op(alu_op),
        .fwd_data(fwd_data), .alu_result(alu_result),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    arithmetic_logic_unit i_arithmetic_logic_unit (
        .alu_op(alu_op), .op1_sel(op1_sel), .op2_sel(op2_sel),
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .fwd_data(fwd_data), .result(alu_result)
    );

endmodule

// File: hw/execute_control.sv
////////////////////
// Four-phase req/ack sequencer with one-deep delayed writeback
// Producer must wait for ack low before the next req
////////////////////
`include "rv_exec_defs.svh"

module execute_control (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  rv_exec_pkg::exec_req_t   req_data,
    output logic                     ack,
    output rv_exec_pkg::exec_rsp_t   rsp,
    output logic [31:0]              instr,
    output logic [`RV_XLEN-1:0]      pc,
    input  rv_exec_pkg::decoded_t    dec,
    input  logic [`RV_XLEN-1:0]      imm,
    output logic [`RV_REG_IDX_W-1:0] rs1_idx,
    output logic [`RV_REG_IDX_W-1:0] rs2_idx,
    output rv_exec_pkg::op1_sel_e    op1_sel,
    output rv_exec_pkg::op2_sel_e    op2_sel,
    output rv_isa_pkg::alu_op_e      alu_op,
    output logic [`RV_XLEN-1:0]      fwd_data,
    input  logic [`RV_XLEN-1:0]      alu_result,
    output logic                     wr_en,
    output logic [`RV_REG_IDX_W-1:0] wr_idx,
    output logic [`RV_XLEN-1:0]      wr_data
);
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, RESPOND} state_e;

    state_e                   state;
    exec_req_t                req_q;        // Captured request
    logic                     pend_valid;   // Result not yet in register file
    logic [`RV_REG_IDX_W-1:0] pend_rd;
    logic [`RV_XLEN-1:0]      pend_data;
    logic                     fwd_rs1, fwd_rs2;
    logic                     new_pend;

    assign instr   = req_q.instr;
    assign pc      = req_q.pc;
    assign rs1_idx = dec.rs1;
    assign rs2_idx = dec.rs2;
    assign alu_op  = dec.alu_op;

    // Forwarding compare against the pending result
    assign fwd_rs1 = dec.uses_rs1 && pend_valid && (pend_rd != '0) && (pend_rd == dec.rs1);
    assign fwd_rs2 = dec.uses_rs2 && pend_valid && (pend_rd != '0) && (pend_rd == dec.rs2);
    assign op1_sel = dec.is_auipc ? SEL1_PC : (fwd_rs1 ? SEL1_FWD : SEL1_RS1);
    assign op2_sel = dec.imm_is_operand ? SEL2_IMM : (fwd_rs2 ? SEL2_FWD : SEL2_RS2);
    assign fwd_data = pend_data;

    assign new_pend  = !dec.illegal && (dec.rd != '0);   // Illegal or x0 never pends

    // Old pending result retires on the edge that registers the new one
    assign wr_en   = (state == EXEC) && pend_valid;
    assign wr_idx  = pend_rd;
    assign wr_data = pend_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            ack        <= 1'b0;
            req_q      <= '0;
            rsp        <= '0;
            pend_valid <= 1'b0;
            pend_rd    <= '0;
            pend_data  <= '0;
        end else begin
            ack <= (state == RESPOND);   // One cycle behind the state
            case (state)
                IDLE: if (req && !ack) begin
                    req_q <= req_data;
                    state <= EXEC;
                end
                EXEC: begin
                    rsp.result  <= dec.illegal ? '0 : alu_result;
                    rsp.rd      <= dec.rd;
                    rsp.illegal <= dec.illegal;
                    pend_valid  <= new_pend;
                    pend_rd     <= dec.rd;
                    pend_data   <= alu_result;
                    state       <= RESPOND;
                end
                RESPOND: if (!req) state <= IDLE;   // Hold rsp while req stays high
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: hw/arithmetic_logic_unit.sv
////////////////////
// RV32I integer ALU with two bypass operand muxes
// Unused select codes fall back to the register operand
////////////////////
`include "rv_exec_defs.svh"

module arithmetic_logic_unit (
    input  rv_isa_pkg::alu_op_e   alu_op,
    input  rv_exec_pkg::op1_sel_e op1_sel,
    input  rv_exec_pkg::op2_sel_e op2_sel,
    input  logic [`RV_XLEN-1:0]   pc,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    input  logic [`RV_XLEN-1:0]   imm,
    input  logic [`RV_XLEN-1:0]   fwd_data,   // Pending result
    output logic [`RV_XLEN-1:0]   result
);
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;

    logic [`RV_XLEN-1:0] operand_1;
    logic [`RV_XLEN-1:0] operand_2;
    logic [4:0]          shamt;

    // Bypass mux for operand 1
    always_comb begin
        case (op1_sel)
            SEL1_FWD: operand_1 = fwd_data;
            SEL1_PC:  operand_1 = pc;
            default:  operand_1 = rs1_data;
        endcase
    end

    // Bypass mux for operand 2
    always_comb begin
        case (op2_sel)
            SEL2_FWD: operand_2 = fwd_data;
            SEL2_IMM: operand_2 = imm;
            default:  operand_2 = rs2_data;
        endcase
    end

    assign shamt = operand_2[4:0];   // RV32 shifts use 5 bits

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = operand_1 + operand_2;
            ALU_SUB:  result = operand_1 - operand_2;
            ALU_SLL:  result = operand_1 << shamt;
            ALU_SLT:  result = {31'b0, $signed(operand_1) < $signed(operand_2)};
            ALU_SLTU: result = {31'b0, operand_1 < operand_2};
            ALU_XOR:  result = operand_1 ^ operand_2;
            ALU_SRL:  result = operand_1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(operand_1) >>> shamt);   // Sign fill
            ALU_OR:   result = operand_1 | operand_2;
            ALU_AND:  result = operand_1 & operand_2;
            default:  result = '0;
        endcase
    end

endmodule

// File: hw/register_file.sv
////////////////////
// 32x32 integer registers, x0 hard wired to zero
// Reads are combinational, so a same-edge write shows next cycle
////////////////////
`include "rv_exec_defs.svh"

module register_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`RV_REG_IDX_W-1:0] rs1_idx,
    input  logic [`RV_REG_IDX_W-1:0] rs2_idx,
    output logic [`RV_XLEN-1:0]      rs1_data,
    output logic [`RV_XLEN-1:0]      rs2_data,
    input  logic                     wr_en,
    input  logic [`RV_REG_IDX_W-1:0] wr_idx,
    input  logic [`RV_XLEN-1:0]      wr_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Write port, clears the whole array on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin   // x0 drops writes
            regs[wr_idx] <= wr_data;
        end
    end

    // Read ports
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: hw/immediate_generator.sv
////////////////////
// I-type and U-type immediates only
// Other opcodes give zero
////////////////////
`include "rv_exec_defs.svh"

module immediate_generator (
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] imm
);
    import rv_isa_pkg::*;

    logic [6:0]          opcode;
    logic [`RV_XLEN-1:0] imm_i;   // Sign-extended instr[31:20]
    logic [`RV_XLEN-1:0] imm_u;   // instr[31:12] in the upper bits

    assign opcode = instr[6:0];
    assign imm_i  = {{(`RV_XLEN - 12){instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    // Shift-immediates reuse imm_i, the ALU only looks at bits 4:0
    always_comb begin
        case (opcode)
            OP_IMM:   imm = imm_i;
            OP_AUIPC: imm = imm_u;
            default:  imm = '0;   // R-type has no immediate
        endcase
    end

endmodule

// File: hw/instruction_decoder.sv
////////////////////
// Decodes RV32I OP, OP-IMM and AUIPC only
// Every other encoding comes out with illegal set
////////////////////
module instruction_decoder (
    input  logic [31:0]          instr,
    output rv_exec_pkg::decoded_t dec
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec                = '0;              // Illegal until matched
        dec.alu_op         = ALU_ADD;
        dec.rd             = instr[11:7];
        dec.rs1            = instr[19:15];
        dec.rs2            = instr[24:20];
        dec.illegal        = 1'b1;
        case (opcode)
            OP_IMM: begin
                dec.uses_rs1       = 1'b1;
                dec.imm_is_operand = 1'b1;
                dec.illegal        = 1'b0;
                case (funct3)
                    F3_ADD:  dec.alu_op = ALU_ADD;    // ADDI
                    F3_SLT:  dec.alu_op = ALU_SLT;    // SLTI
                    F3_SLTU: dec.alu_op = ALU_SLTU;   // SLTIU
                    F3_XOR:  dec.alu_op = ALU_XOR;
                    F3_OR:   dec.alu_op = ALU_OR;
                    F3_AND:  dec.alu_op = ALU_AND;
                    F3_SLL: begin
                        dec.alu_op  = ALU_SLL;
                        dec.illegal = (funct7 != FUNCT7_BASE);   // Bad SLLI
                    end
                    default: begin                               // SRLI/SRAI
                        dec.alu_op  = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                        dec.illegal = (funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT);
                    end
                endcase
            end
            OP_REG: begin
                dec.uses_rs1 = 1'b1;
                dec.uses_rs2 = 1'b1;
                dec.illegal  = 1'b0;
                case ({funct7, funct3})
                    {FUNCT7_BASE, F3_ADD}:  dec.alu_op = ALU_ADD;
                    {FUNCT7_ALT,  F3_ADD}:  dec.alu_op = ALU_SUB;
                    {FUNCT7_BASE, F3_SLL}:  dec.alu_op = ALU_SLL;
                    {FUNCT7_BASE, F3_SLT}:  dec.alu_op = ALU_SLT;
                    {FUNCT7_BASE, F3_SLTU}: dec.alu_op = ALU_SLTU;
                    {FUNCT7_BASE, F3_XOR}:  dec.alu_op = ALU_XOR;
                    {FUNCT7_BASE, F3_SR}:   dec.alu_op = ALU_SRL;
                    {FUNCT7_ALT,  F3_SR}:   dec.alu_op = ALU_SRA;
                    {FUNCT7_BASE, F3_OR}:   dec.alu_op = ALU_OR;
                    {FUNCT7_BASE, F3_AND}:  dec.alu_op = ALU_AND;
                    default:                dec.illegal = 1'b1;   // Unknown funct
                endcase
            end
            OP_AUIPC: begin
                dec.alu_op         = ALU_ADD;   // PC + upper immediate
                dec.imm_is_operand = 1'b1;
                dec.is_auipc       = 1'b1;
                dec.illegal        = 1'b0;
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// File: hw/rv_exec_pkg.sv
////////////////////
// Slice-level buses and operand selects
// Select encodings follow the bypass mux order of the ALU
////////////////////
`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // First operand source
    typedef enum logic [1:0] {
        SEL1_RS1 = 2'b00,   // Register file
        SEL1_FWD = 2'b01,   // Pending result
        SEL1_PC  = 2'b10    // AUIPC
    } op1_sel_e;

    // Second operand source
    typedef enum logic [1:0] {
        SEL2_RS2 = 2'b00,
        SEL2_FWD = 2'b01,
        SEL2_IMM = 2'b10
    } op2_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;      // PC of the instruction
        logic [31:0]         instr;   // Raw instruction word
    } exec_req_t;

    typedef struct packed {
        rv_isa_pkg::alu_op_e      alu_op;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic                     uses_rs1;
        logic                     uses_rs2;
        logic                     imm_is_operand;   // Operand 2 from immediate
        logic                     is_auipc;         // Operand 1 from PC
        logic                     illegal;
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]      result;
        logic [`RV_REG_IDX_W-1:0] rd;
        logic                     illegal;   // No register written
    } exec_rsp_t;

endpackage

// File: hw/rv_isa_pkg.sv
////////////////////
// RV32I encodings seen by the execute slice
// Only the integer ALU opcodes and AUIPC are listed
////////////////////
package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,   // Register-immediate ALU
        OP_REG   = 7'b0110011,   // Register-register ALU
        OP_AUIPC = 7'b0010111    // Add upper immediate to PC
    } opcode_e;

    // Internal ALU operation codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,   // Signed compare
        ALU_SLTU = 4'd4,   // Unsigned compare
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,   // Arithmetic right shift
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // funct7 values that matter for the ALU
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;   // SUB and SRA/SRAI

    // funct3 values shared by OP_IMM and OP_REG
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

// File: hw/rv_exec_defs.svh
////////////////////
// Fixed RV32I widths for the execute slice
// Changing them is not supported since the ISA fields are hard coded
////////////////////
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// Data path and PC width
`define RV_XLEN 32

// Architectural integer registers
`define RV_REG_COUNT 32

// Bits needed to address one register
`define RV_REG_IDX_W 5

`endif
